// File: hdl/ddr_stream_macros.svh
/*
  bridge parameters shared by the package and the engines
  beats are 64 bytes wide and a burst is 64 beats, so BURST_BYTES,
  BURST_LEN, BEAT_SHIFT and DATA_W must be changed together
*/
`ifndef DDR_STREAM_MACROS_SVH
`define DDR_STREAM_MACROS_SVH

// bus widths
`define DS_ADDR_W 34
`define DS_DATA_W 512
`define DS_ID_W 6

// burst shape
`define DS_BURST_BYTES 4096
`define DS_BURST_LEN 63
`define DS_BEAT_SHIFT 6

// watermark lead required before a read-ahead burst
`define DS_RD_MARGIN 8192

// host id that is tracked on DDR A and gated on DDR C
`define DS_TRACK_ID 0
// id of the bridge's own bursts
`define DS_ENGINE_ID 1

// outstanding tracked host writes
`define DS_FIFO_DEPTH 16

`endif

// File: hdl/ddr_stream_pkg.sv
/*
  types shared by the streaming bridge
  AW and AR carry only id, address and len; the other AXI sidebands
  are tied off outside the bridge
*/
`include "ddr_stream_macros.svh"

package ddr_stream_pkg;

  // ------------------------------
  // plain vectors
  // ------------------------------
  typedef logic [`DS_ADDR_W-1:0] addr_t;
  typedef logic [`DS_DATA_W-1:0] data_t;
  typedef logic [`DS_ID_W-1:0] id_t;
  typedef logic [7:0] len_t;
  typedef logic [1:0] resp_t;

  // ------------------------------
  // channel payloads
  // ------------------------------

  // AW and AR request
  typedef struct packed {
    id_t id;
    addr_t addr;
    len_t len;
  } addr_req_t;

  // B response, 2'b00 is OKAY
  typedef struct packed {
    id_t id;
    resp_t resp;
  } wr_rsp_t;

  // image write-back FSM
  typedef enum logic [1:0] {
    WB_IDLE,
    WB_ADDR,
    WB_DATA
  } wb_state_t;

endpackage

// File: hdl/wr_track.sv
/*
  tracks host writes with id DS_TRACK_ID and moves the watermark over
  completions that are in order and contiguous
  B responses must come back in AW order; a B in the same cycle as its
  own AW is not seen, and AWs beyond DS_FIFO_DEPTH outstanding are lost
*/
`timescale 1ns/1ns
`include "ddr_stream_macros.svh"

module wr_track (
  input logic aclk,
  input logic aresetn,
  input ddr_stream_pkg::addr_req_t aw,
  input logic aw_fire,
  input ddr_stream_pkg::wr_rsp_t b,
  input logic b_fire,
  output ddr_stream_pkg::addr_t written_until
);

  import ddr_stream_pkg::*;

  localparam int PTR_W = $clog2(`DS_FIFO_DEPTH);

  addr_t start_mem [`DS_FIFO_DEPTH];
  addr_t end_mem [`DS_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] count;
  logic push;
  logic pop;
  logic okay;
  addr_t aw_end;

  // first byte past the burst
  assign aw_end = aw.addr + ((addr_t'(aw.len) + addr_t'(1)) << `DS_BEAT_SHIFT);

  assign push = aw_fire && (aw.id == `DS_TRACK_ID) && (count != `DS_FIFO_DEPTH);
  // every tracked completion pops, so the FIFO stays aligned with the B order
  assign pop = b_fire && (b.id == `DS_TRACK_ID) && (count != 0);
  assign okay = (b.resp == 2'b00);

  // ------------------------------
  // address pair storage
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (push) begin
      start_mem[wr_ptr] <= aw.addr;
      end_mem[wr_ptr] <= aw_end;
    end
  end

  // ------------------------------
  // pointers and watermark
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      written_until <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      // a write that starts past the watermark leaves a hole, skip it
      if (pop && okay && (start_mem[rd_ptr] <= written_until)) begin
        written_until <= end_mem[rd_ptr];
      end
    end
  end

endmodule

// File: hdl/read_ahead.sv
/*
  issues 4 KiB read-ahead bursts on DDR A behind the write watermark
  one burst is outstanding on AR at a time; read data is not checked here
*/
`timescale 1ns/1ns
`include "ddr_stream_macros.svh"

module read_ahead (
  input logic aclk,
  input logic aresetn,
  input ddr_stream_pkg::addr_t written_until,
  output ddr_stream_pkg::addr_req_t ar,
  output logic ar_valid,
  input logic ar_ready
);

  import ddr_stream_pkg::*;

  addr_t rd_ptr;
  logic ahead;

  // watermark leads the read pointer by the full margin
  assign ahead = (written_until > rd_ptr) &&
                 ((written_until - rd_ptr) >= addr_t'(`DS_RD_MARGIN));

  assign ar = '{
    id: id_t'(`DS_ENGINE_ID),
    addr: rd_ptr,
    len: len_t'(`DS_BURST_LEN)
  };

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_ptr <= '0;
      ar_valid <= 1'b0;
    end else begin
      if (ar_valid && ar_ready) begin
        rd_ptr <= rd_ptr + addr_t'(`DS_BURST_BYTES);
        ar_valid <= 1'b0;
      end else if (!ar_valid && ahead) begin
        ar_valid <= 1'b1;
      end
    end
  end

endmodule

// File: hdl/img_writeback.sv
/*
  writes two 4 KiB bursts of the accelerator output to DDR C per image
  both AWs go out before the first W beat, and beats come at most every
  other cycle; B responses are not waited for
*/
`timescale 1ns/1ns
`include "ddr_stream_macros.svh"

module img_writeback (
  input logic aclk,
  input logic aresetn,
  input logic img_buffered,
  output ddr_stream_pkg::addr_req_t aw,
  output logic aw_valid,
  input logic aw_ready,
  output ddr_stream_pkg::data_t wdata,
  output logic wlast,
  output logic w_valid,
  input logic w_ready,
  input ddr_stream_pkg::data_t fifo_out_bits,
  input logic fifo_out_vld,
  output logic fifo_out_rdy
);

  import ddr_stream_pkg::*;

  localparam int BURST_BEATS = `DS_BURST_LEN + 1;
  localparam int IMG_BEATS = 2 * BURST_BEATS;

  wb_state_t state;
  addr_t wr_ptr;
  logic second_aw;
  logic [$clog2(IMG_BEATS)-1:0] beat_cnt;
  logic pace;
  logic w_fire;

  assign aw = '{
    id: id_t'(`DS_ENGINE_ID),
    addr: wr_ptr,
    len: len_t'(`DS_BURST_LEN)
  };
  assign aw_valid = (state == WB_ADDR);

  // beat may go only in the cycle after the pace toggle was armed
  assign w_valid = (state == WB_DATA) && fifo_out_vld && pace;
  assign fifo_out_rdy = (state == WB_DATA) && w_ready && pace;
  assign w_fire = w_valid && w_ready;
  assign wdata = fifo_out_bits;
  assign wlast = &beat_cnt[$clog2(BURST_BEATS)-1:0];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= WB_IDLE;
      wr_ptr <= '0;
      second_aw <= 1'b0;
      beat_cnt <= '0;
      pace <= 1'b0;
    end else begin
      pace <= fifo_out_vld && w_ready && !pace;
      case (state)
        WB_IDLE: begin
          if (img_buffered) begin
            state <= WB_ADDR;
            second_aw <= 1'b0;
          end
        end
        WB_ADDR: begin
          if (aw_valid && aw_ready) begin
            wr_ptr <= wr_ptr + addr_t'(`DS_BURST_BYTES);
            second_aw <= 1'b1;
            if (second_aw) begin
              state <= WB_DATA;
              beat_cnt <= '0;
            end
          end
        end
        WB_DATA: begin
          if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (&beat_cnt) begin
              state <= WB_IDLE;
            end
          end
        end
        default: state <= WB_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/host_rd_gate.sv
/*
  holds tracked host reads of DDR C until the write-back has covered them
  the completed count assumes write-back starts at address 0 and grows
  in 4 KiB steps; other ids are granted without a check
*/
`timescale 1ns/1ns
`include "ddr_stream_macros.svh"

module host_rd_gate (
  input logic aclk,
  input logic aresetn,
  input ddr_stream_pkg::addr_req_t host_ar,
  input logic host_ar_valid,
  output logic host_ar_ready,
  output logic ddr_ar_valid,
  input logic ddr_ar_ready,
  input ddr_stream_pkg::wr_rsp_t b,
  input logic b_valid
);

  import ddr_stream_pkg::*;

  addr_t done_bytes;
  addr_t req_end;
  logic pass;
  logic grant;
  logic hold;

  assign req_end = host_ar.addr + ((addr_t'(host_ar.len) + addr_t'(1)) << `DS_BEAT_SHIFT);
  assign pass = (host_ar.id != `DS_TRACK_ID) || (done_bytes >= req_end);

  // one-cycle window, both sides follow DDR C arready
  assign ddr_ar_valid = grant && ddr_ar_ready;
  assign host_ar_ready = grant && ddr_ar_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      done_bytes <= '0;
      grant <= 1'b0;
      hold <= 1'b0;
    end else begin
      // bready is tied high, so valid alone completes a B
      if (b_valid && (b.id == `DS_ENGINE_ID) && (b.resp == 2'b00)) begin
        done_bytes <= done_bytes + addr_t'(`DS_BURST_BYTES);
      end
      grant <= 1'b0;
      hold <= 1'b0;
      // a failed check waits one idle cycle before the next one
      if (host_ar_valid && ddr_ar_ready && !grant && !hold) begin
        grant <= pass;
        hold <= !pass;
      end
    end
  end

endmodule

// File: hdl/ddr_stream_top.sv
/*
  DDR streaming bridge between the host DMA port, DDR A and DDR C
  host W and R data are routed outside; only AW, B and AR pass here
  addresses are assumed to grow without wrapping
*/
`timescale 1ns/1ns
`include "ddr_stream_macros.svh"

module ddr_stream_top (
  input logic aclk,
  input logic aresetn,
  // host
  input ddr_stream_pkg::addr_req_t host_aw,
  input logic host_aw_valid,
  output logic host_aw_ready,
  output ddr_stream_pkg::wr_rsp_t host_b,
  output logic host_b_valid,
  input logic host_b_ready,
  input ddr_stream_pkg::addr_req_t host_ar,
  input logic host_ar_valid,
  output logic host_ar_ready,
  // DDR A
  output ddr_stream_pkg::addr_req_t ddra_aw,
  output logic ddra_aw_valid,
  input logic ddra_aw_ready,
  input ddr_stream_pkg::wr_rsp_t ddra_b,
  input logic ddra_b_valid,
  output logic ddra_b_ready,
  output ddr_stream_pkg::addr_req_t ddra_ar,
  output logic ddra_ar_valid,
  input logic ddra_ar_ready,
  input ddr_stream_pkg::data_t ddra_r_data,
  input logic ddra_r_valid,
  output logic ddra_r_ready,
  // DDR C
  output ddr_stream_pkg::addr_req_t ddrc_aw,
  output logic ddrc_aw_valid,
  input logic ddrc_aw_ready,
  output ddr_stream_pkg::data_t ddrc_w_data,
  output logic [`DS_DATA_W/8-1:0] ddrc_w_strb,
  output logic ddrc_w_last,
  output logic ddrc_w_valid,
  input logic ddrc_w_ready,
  input ddr_stream_pkg::wr_rsp_t ddrc_b,
  input logic ddrc_b_valid,
  output logic ddrc_b_ready,
  output ddr_stream_pkg::addr_req_t ddrc_ar,
  output logic ddrc_ar_valid,
  input logic ddrc_ar_ready,
  // accelerator
  output ddr_stream_pkg::data_t fifo_in_bits,
  output logic fifo_in_vld,
  input logic fifo_in_rdy,
  input ddr_stream_pkg::data_t fifo_out_bits,
  input logic fifo_out_vld,
  output logic fifo_out_rdy,
  input logic img_buffered
);

  import ddr_stream_pkg::*;

  addr_t written_until;
  logic aw_fire;
  logic b_fire;

  // ------------------------------
  // pass-through channels
  // ------------------------------
  assign ddra_aw = host_aw;
  assign ddra_aw_valid = host_aw_valid;
  assign host_aw_ready = ddra_aw_ready;
  assign host_b = ddra_b;
  assign host_b_valid = ddra_b_valid;
  assign ddra_b_ready = host_b_ready;
  assign fifo_in_bits = ddra_r_data;
  assign fifo_in_vld = ddra_r_valid;
  assign ddra_r_ready = fifo_in_rdy;
  assign ddrc_ar = host_ar;
  assign ddrc_w_strb = '1;
  assign ddrc_b_ready = 1'b1;

  // snooped handshakes on DDR A
  assign aw_fire = host_aw_valid && ddra_aw_ready;
  assign b_fire = ddra_b_valid && host_b_ready;

  // ------------------------------
  // engines
  // ------------------------------
  wr_track wr_track_i (
    .aclk(aclk),
    .aresetn(aresetn),
    .aw(host_aw),
    .aw_fire(aw_fire),
    .b(ddra_b),
    .b_fire(b_fire),
    .written_until(written_until)
  );

  read_ahead read_ahead_i (
    .aclk(aclk),
    .aresetn(aresetn),
    .written_until(written_until),
    .ar(ddra_ar),
    .ar_valid(ddra_ar_valid),
    .ar_ready(ddra_ar_ready)
  );

  img_writeback img_writeback_i (
    .aclk(aclk),
    .aresetn(aresetn),
    .img_buffered(img_buffered),
    .aw(ddrc_aw),
    .aw_valid(ddrc_aw_valid),
    .aw_ready(ddrc_aw_ready),
    .wdata(ddrc_w_data),
    .wlast(ddrc_w_last),
    .w_valid(ddrc_w_valid),
    .w_ready(ddrc_w_ready),
    .fifo_out_bits(fifo_out_bits),
    .fifo_out_vld(fifo_out_vld),
    .fifo_out_rdy(fifo_out_rdy)
  );

  host_rd_gate host_rd_gate_i (
    .aclk(aclk),
    .aresetn(aresetn),
    .host_ar(host_ar),
    .host_ar_valid(host_ar_valid),
    .host_ar_ready(host_ar_ready),
    .ddr_ar_valid(ddrc_ar_valid),
    .ddr_ar_ready(ddrc_ar_ready),
    .b(ddrc_b),
    .b_valid(ddrc_b_valid)
  );

endmodule

// File: verif/tb_clock.sv
/*
  clock and reset for the bridge testbench
  aclk has an 8 ns period, aresetn is released 1 ns after the second edge
*/
`timescale 1ns/1ns

module tb_clock (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  initial begin
    aresetn = 1'b0;
    repeat (2) @(posedge aclk);
    #1 aresetn = 1'b1;
  end

endmodule

// File: verif/ddr_stream_tb.sv
/*
  testbench for the DDR streaming bridge
  DDR A and DDR C only give random ready and in-order B responses
  W and R data are not stored; the output stream is a numbered pattern
*/
`timescale 1ns/1ns
`include "ddr_stream_macros.svh"

module ddr_stream_tb;

  import ddr_stream_pkg::*;

  localparam int NUM_WR = 24;
  localparam int NUM_BURSTS = NUM_WR + 7;
  localparam int TIMEOUT_NS = 200 * NUM_BURSTS * 8;

  logic aclk;
  logic aresetn;
  addr_req_t host_aw;
  logic host_aw_valid;
  logic host_aw_ready;
  wr_rsp_t host_b;
  logic host_b_valid;
  logic host_b_ready;
  addr_req_t host_ar;
  logic host_ar_valid;
  logic host_ar_ready;
  addr_req_t ddra_aw;
  logic ddra_aw_valid;
  logic ddra_aw_ready;
  wr_rsp_t ddra_b;
  logic ddra_b_valid;
  logic ddra_b_ready;
  addr_req_t ddra_ar;
  logic ddra_ar_valid;
  logic ddra_ar_ready;
  data_t ddra_r_data;
  logic ddra_r_valid;
  logic ddra_r_ready;
  addr_req_t ddrc_aw;
  logic ddrc_aw_valid;
  logic ddrc_aw_ready;
  data_t ddrc_w_data;
  logic [`DS_DATA_W/8-1:0] ddrc_w_strb;
  logic ddrc_w_last;
  logic ddrc_w_valid;
  logic ddrc_w_ready;
  wr_rsp_t ddrc_b;
  logic ddrc_b_valid;
  logic ddrc_b_ready;
  addr_req_t ddrc_ar;
  logic ddrc_ar_valid;
  logic ddrc_ar_ready;
  data_t fifo_in_bits;
  logic fifo_in_vld;
  logic fifo_in_rdy;
  data_t fifo_out_bits;
  logic fifo_out_vld;
  logic fifo_out_rdy;
  logic img_buffered;

  // reference model state
  addr_t m_wm;
  addr_t m_rd;
  addr_t m_wp;
  addr_t m_done;
  int m_aw_cnt;
  int m_beat;
  int m_wseq;
  int cyc;
  addr_t trk_start[$];
  addr_t trk_end[$];
  wr_rsp_t a_b_rsp[$];
  int a_b_due[$];
  int c_b_due[$];
  addr_t ar_end;
  len_t wr_len [NUM_WR];
  logic [31:0] rng = 32'h7d82;
  int out_seq = 0;
  logic stim_on = 1'b0;

  tb_clock tb_clock_i (.aclk(aclk), .aresetn(aresetn));

  ddr_stream_top dut_i (.*);

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      rng = lfsr_step(rng);
      v = {v[30:0], rng[0]};
    end
  endtask

  function automatic addr_t burst_end(input addr_req_t r);
    return r.addr + (addr_t'(r.len) + addr_t'(1)) * addr_t'(64);
  endfunction

  function automatic data_t beat_pattern(input int n);
    return {16{32'h5a000000 ^ 32'(n)}};
  endfunction

  function automatic addr_req_t engine_req(input addr_t a);
    return '{id: id_t'(`DS_ENGINE_ID), addr: a, len: len_t'(`DS_BURST_LEN)};
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic mismatch(input string sig, input logic [511:0] got, input logic [511:0] exp);
    fail_run($sformatf("Mismatch at %0t: %s dut=%0h expected=%0h", $time, sig, got, exp));
  endtask

  task automatic send_host_aw(input id_t id, input addr_t addr, input len_t len,
                              input resp_t resp);
    wr_rsp_t rsp;
    host_aw = '{id: id, addr: addr, len: len};
    host_aw_valid = 1'b1;
    @(posedge aclk);
    while (!host_aw_ready) @(posedge aclk);
    #1;
    host_aw_valid = 1'b0;
    rsp = '{id: id, resp: resp};
    a_b_rsp.push_back(rsp);
    a_b_due.push_back(cyc + 4);
  endtask

  task automatic offer_host_ar(input id_t id, input addr_t addr, input len_t len);
    host_ar = '{id: id, addr: addr, len: len};
    ar_end = burst_end(host_ar);
    host_ar_valid = 1'b1;
  endtask

  task automatic wait_host_ar();
    @(posedge aclk);
    while (!host_ar_ready) @(posedge aclk);
    #1;
    host_ar_valid = 1'b0;
  endtask

  // ------------------------------
  // DDR models and accelerator
  // ------------------------------
  always @(posedge aclk) begin
    logic [31:0] r;
    logic [31:0] d;
    logic out_fire;
    out_fire = fifo_out_vld && fifo_out_rdy;
    #1;
    draw(12, r);
    draw(16, d);
    ddra_aw_ready = r[0] | r[1];
    ddra_ar_ready = r[2];
    ddrc_aw_ready = r[3];
    ddrc_w_ready = r[4] | r[5];
    ddrc_ar_ready = r[6] | r[7];
    ddra_r_valid = r[8];
    fifo_in_rdy = r[9];
    ddra_r_data = {32{d[15:0]}};
    if (out_fire) begin
      out_seq = out_seq + 1;
      fifo_out_bits = beat_pattern(out_seq);
    end
    // a raised stream valid waits for its transfer
    if (out_fire || !fifo_out_vld) begin
      fifo_out_vld = r[10] | r[11];
    end
  end

  always @(posedge aclk) begin
    logic taken;
    taken = ddra_b_valid && host_b_ready;
    #1;
    if (taken) begin
      ddra_b_valid = 1'b0;
      a_b_rsp.delete(0);
      a_b_due.delete(0);
    end else if (!ddra_b_valid && a_b_rsp.size() != 0 && cyc >= a_b_due[0]) begin
      ddra_b = a_b_rsp[0];
      ddra_b_valid = 1'b1;
    end
  end

  always @(posedge aclk) begin
    logic last_beat;
    last_beat = ddrc_w_valid && ddrc_w_ready && ddrc_w_last;
    #1;
    ddrc_b_valid = 1'b0;
    if (last_beat) begin
      c_b_due.push_back(cyc + 3);
    end
    if (c_b_due.size() != 0 && cyc >= c_b_due[0]) begin
      ddrc_b_valid = 1'b1;
      c_b_due.delete(0);
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------
  always @(posedge aclk) begin
    if (!aresetn) begin
      cyc <= 0;
      m_wm <= '0;
      m_rd <= '0;
      m_wp <= '0;
      m_done <= '0;
      m_aw_cnt <= 2;
      m_beat <= 128;
      m_wseq <= 0;
      trk_start.delete();
      trk_end.delete();
    end else begin
      cyc <= cyc + 1;
      if (ddra_b_valid && host_b_ready && ddra_b.id == id_t'(`DS_TRACK_ID) &&
          trk_start.size() != 0) begin
        if (ddra_b.resp == 2'b00 && trk_start[0] <= m_wm) begin
          m_wm <= trk_end[0];
        end
        trk_start.delete(0);
        trk_end.delete(0);
      end
      if (host_aw_valid && host_aw_ready && host_aw.id == id_t'(`DS_TRACK_ID)) begin
        trk_start.push_back(host_aw.addr);
        trk_end.push_back(burst_end(host_aw));
      end
      if (ddra_ar_valid && ddra_ar_ready) begin
        m_rd <= m_rd + addr_t'(`DS_BURST_BYTES);
      end
      if (img_buffered) begin
        m_aw_cnt <= 0;
        m_beat <= 0;
      end else begin
        if (ddrc_aw_valid && ddrc_aw_ready) begin
          m_wp <= m_wp + addr_t'(`DS_BURST_BYTES);
          m_aw_cnt <= m_aw_cnt + 1;
        end
        if (ddrc_w_valid && ddrc_w_ready) begin
          m_beat <= m_beat + 1;
          m_wseq <= m_wseq + 1;
        end
      end
      if (ddrc_b_valid && ddrc_b.id == id_t'(`DS_ENGINE_ID) && ddrc_b.resp == 2'b00) begin
        m_done <= m_done + addr_t'(`DS_BURST_BYTES);
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  reset_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
    !stim_on |-> !ddra_ar_valid && !ddrc_aw_valid && !ddrc_w_valid && !host_ar_ready)
    else fail_run("a DUT valid or ready output went high before any stimulus");
  aw_pass: assert property (@(posedge aclk) disable iff (!aresetn)
    {ddra_aw, ddra_aw_valid, host_aw_ready} == {host_aw, host_aw_valid, ddra_aw_ready})
    else mismatch("ddra_aw/ddra_aw_valid/host_aw_ready",
                  $sampled({ddra_aw, ddra_aw_valid, host_aw_ready}),
                  $sampled({host_aw, host_aw_valid, ddra_aw_ready}));
  b_pass: assert property (@(posedge aclk) disable iff (!aresetn)
    {host_b, host_b_valid, ddra_b_ready} == {ddra_b, ddra_b_valid, host_b_ready})
    else mismatch("host_b/host_b_valid/ddra_b_ready",
                  $sampled({host_b, host_b_valid, ddra_b_ready}),
                  $sampled({ddra_b, ddra_b_valid, host_b_ready}));
  c_ties: assert property (@(posedge aclk) disable iff (!aresetn)
    {ddrc_w_strb, ddrc_b_ready} == {{(`DS_DATA_W/8){1'b1}}, 1'b1})
    else mismatch("ddrc_w_strb/ddrc_b_ready", $sampled({ddrc_w_strb, ddrc_b_ready}),
                  {{(`DS_DATA_W/8){1'b1}}, 1'b1});
  wm_match: assert property (@(posedge aclk) disable iff (!aresetn)
    dut_i.wr_track_i.written_until == m_wm)
    else mismatch("written_until", $sampled(dut_i.wr_track_i.written_until), $sampled(m_wm));
  ar_margin: assert property (@(posedge aclk) disable iff (!aresetn)
    ddra_ar_valid |-> m_wm >= m_rd + addr_t'(`DS_RD_MARGIN))
    else fail_run("DDR A AR offered before the watermark led by the margin");
  ar_rise: assert property (@(posedge aclk) disable iff (!aresetn)
    (!ddra_ar_valid && m_wm >= m_rd + addr_t'(`DS_RD_MARGIN)) |=> ddra_ar_valid)
    else fail_run("DDR A AR did not rise one cycle after the margin was reached");
  ar_drop: assert property (@(posedge aclk) disable iff (!aresetn)
    (ddra_ar_valid && ddra_ar_ready) |=> !ddra_ar_valid)
    else fail_run("DDR A AR valid stayed high after its transfer");
  ar_req: assert property (@(posedge aclk) disable iff (!aresetn)
    ddra_ar_valid |-> ddra_ar == engine_req(m_rd))
    else mismatch("ddra_ar", $sampled(ddra_ar), $sampled(engine_req(m_rd)));
  r_data_path: assert property (@(posedge aclk) disable iff (!aresetn)
    fifo_in_bits == ddra_r_data)
    else mismatch("fifo_in_bits", $sampled(fifo_in_bits), $sampled(ddra_r_data));
  r_valid_path: assert property (@(posedge aclk) disable iff (!aresetn)
    fifo_in_vld == ddra_r_valid)
    else mismatch("fifo_in_vld", $sampled(fifo_in_vld), $sampled(ddra_r_valid));
  r_ready_path: assert property (@(posedge aclk) disable iff (!aresetn)
    ddra_r_ready == fifo_in_rdy)
    else mismatch("ddra_r_ready", $sampled(ddra_r_ready), $sampled(fifo_in_rdy));
  c_aw_req: assert property (@(posedge aclk) disable iff (!aresetn)
    ddrc_aw_valid |-> ddrc_aw == engine_req(m_wp))
    else mismatch("ddrc_aw", $sampled(ddrc_aw), $sampled(engine_req(m_wp)));
  c_aw_count: assert property (@(posedge aclk) disable iff (!aresetn)
    ddrc_aw_valid |-> m_aw_cnt < 2)
    else fail_run("DDR C AW offered beyond the two bursts of an image");
  c_w_order: assert property (@(posedge aclk) disable iff (!aresetn)
    ddrc_w_valid |-> m_aw_cnt == 2 && m_beat < 128)
    else fail_run("DDR C W offered outside the 128 beats after both AWs");
  c_w_stream: assert property (@(posedge aclk) disable iff (!aresetn)
    (fifo_out_vld && fifo_out_rdy) == (ddrc_w_valid && ddrc_w_ready))
    else fail_run("an output stream transfer did not line up with a DDR C W transfer");
  c_w_data: assert property (@(posedge aclk) disable iff (!aresetn)
    (ddrc_w_valid && ddrc_w_ready) |-> ddrc_w_data == beat_pattern(m_wseq))
    else mismatch("ddrc_w_data", $sampled(ddrc_w_data), $sampled(beat_pattern(m_wseq)));
  c_w_last: assert property (@(posedge aclk) disable iff (!aresetn)
    ddrc_w_valid |-> ddrc_w_last == (m_beat == 63 || m_beat == 127))
    else mismatch("ddrc_w_last", $sampled(ddrc_w_last), $sampled(m_beat == 63 || m_beat == 127));
  c_w_gap: assert property (@(posedge aclk) disable iff (!aresetn)
    (ddrc_w_valid && ddrc_w_ready) |=> !(ddrc_w_valid && ddrc_w_ready))
    else fail_run("two DDR C W transfers in adjacent cycles");
  gate_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    ddrc_ar_valid |-> host_ar_valid && (host_ar.id != id_t'(`DS_TRACK_ID) || m_done >= ar_end))
    else fail_run("host read granted before its data was written back");
  gate_req: assert property (@(posedge aclk) disable iff (!aresetn)
    ddrc_ar_valid |-> ddrc_ar == host_ar)
    else mismatch("ddrc_ar", $sampled(ddrc_ar), $sampled(host_ar));
  gate_ready: assert property (@(posedge aclk) disable iff (!aresetn)
    host_ar_ready == ddrc_ar_valid)
    else mismatch("host_ar_ready", $sampled(host_ar_ready), $sampled(ddrc_ar_valid));

  initial begin
    #(TIMEOUT_NS);
    fail_run("watchdog expired before the test sequence finished");
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    logic [31:0] v;
    addr_t next_addr;
    host_aw = '0;
    host_aw_valid = 1'b0;
    host_b_ready = 1'b1;
    host_ar = '0;
    host_ar_valid = 1'b0;
    ddra_aw_ready = 1'b0;
    ddra_b = '0;
    ddra_b_valid = 1'b0;
    ddra_ar_ready = 1'b0;
    ddra_r_data = '0;
    ddra_r_valid = 1'b0;
    ddrc_aw_ready = 1'b0;
    ddrc_w_ready = 1'b0;
    ddrc_b = '{id: id_t'(`DS_ENGINE_ID), resp: 2'b00};
    ddrc_b_valid = 1'b0;
    ddrc_ar_ready = 1'b0;
    fifo_in_rdy = 1'b0;
    fifo_out_bits = beat_pattern(0);
    fifo_out_vld = 1'b0;
    img_buffered = 1'b0;
    for (int i = 0; i < NUM_WR; i++) begin
      draw(6, v);
      wr_len[i] = len_t'(v[5:0]);
    end
    wait (aresetn === 1'b1);
    repeat (4) @(posedge aclk);
    #1;
    stim_on = 1'b1;
    next_addr = '0;
    for (int i = 0; i < NUM_WR; i++) begin
      if (i == 6) begin
        // error response, written again at the same address
        send_host_aw(id_t'(0), next_addr, wr_len[i], 2'b10);
      end
      if (i == 11) begin
        send_host_aw(id_t'(0), addr_t'(34'h2_0000_0000), len_t'(3), 2'b00);
      end
      send_host_aw(id_t'(0), next_addr, wr_len[i], 2'b00);
      next_addr = next_addr + ((addr_t'(wr_len[i]) + addr_t'(1)) << `DS_BEAT_SHIFT);
    end
    while (a_b_rsp.size() != 0 || ddra_b_valid) @(posedge aclk);
    while (ddra_ar_valid || m_wm >= m_rd + addr_t'(`DS_RD_MARGIN)) @(posedge aclk);
    if (m_rd == '0) begin
      fail_run("no read-ahead burst was issued on DDR A");
    end
    #1;
    offer_host_ar(id_t'(3), addr_t'(34'h2_0000), len_t'(15));
    wait_host_ar();
    // needs the first write-back burst
    offer_host_ar(id_t'(0), addr_t'(0), len_t'(63));
    repeat (8) @(posedge aclk);
    #1;
    img_buffered = 1'b1;
    @(posedge aclk);
    #1;
    img_buffered = 1'b0;
    wait_host_ar();
    while (m_beat < 128) @(posedge aclk);
    while (c_b_due.size() != 0 || ddrc_b_valid) @(posedge aclk);
    @(posedge aclk);
    if (dut_i.host_rd_gate_i.done_bytes != m_done) begin
      mismatch("done_bytes", dut_i.host_rd_gate_i.done_bytes, m_done);
    end
    if (m_done != addr_t'(2 * `DS_BURST_BYTES)) begin
      fail_run("DDR C did not complete both write-back bursts");
    end
    #1;
    offer_host_ar(id_t'(0), addr_t'(`DS_BURST_BYTES), len_t'(63));
    wait_host_ar();
    repeat (4) @(posedge aclk);
    $display("All tests passed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+hdl
hdl/ddr_stream_pkg.sv
hdl/wr_track.sv
hdl/read_ahead.sv
hdl/img_writeback.sv
hdl/host_rd_gate.sv
hdl/ddr_stream_top.sv
verif/tb_clock.sv
verif/ddr_stream_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module ddr_stream_tb \
  -o ddr_stream_sim || exit 1
./obj_dir/ddr_stream_sim 2>&1 | tee sim.log
grep -q "Some tests failed" sim.log && exit 1 || grep -q "All tests passed" sim.log
